//--- rtl/mem_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared widths, APB address map and FSM state types for the APB memory
// block with its summing engine. Modules import it inside their bodies
// and use scoped names in their port lists.
////////////////////////////////////////////////////////////////////////////

package mem_pkg;

   localparam int DATA_W      = 32;  // Data word width
   localparam int PADDR_W     = 12;  // APB byte address width
   localparam int ADDR_W      = 8;   // RAM word address, 256 words
   localparam int REG_SEL_BIT = 11;  // Set selects registers, clear selects memory

   // Register map, upper half of the APB window
   localparam logic [PADDR_W-1:0] REG_BASE = 12'h800;  // Start word address
   localparam logic [PADDR_W-1:0] REG_LEN  = 12'h804;  // Word count, 0 to 256
   localparam logic [PADDR_W-1:0] REG_CTRL = 12'h808;  // W bit0 start, R bit0 busy
   localparam logic [PADDR_W-1:0] REG_SUM  = 12'h80C;  // Last sum, read only

   // APB slave FSM
   typedef enum logic [1:0] {
      APB_IDLE,      // Waiting for a setup phase
      APB_MEM_WAIT,  // Memory access held or read in flight
      APB_MEM_DONE,  // Response cycle, register transfers use it too
      APB_ERR        // Response cycle with slave error
   } apb_state_t;

   // Summing engine FSM
   typedef enum logic [1:0] {
      SUM_IDLE,
      SUM_RUN,    // One RAM read per cycle
      SUM_DRAIN   // Wait for reads in flight
   } sum_state_t;

   // RAM read latency, one cycle more with the output register
   function automatic int read_lat(input int out_reg);
      return (out_reg != 0) ? 2 : 1;
   endfunction

endpackage

//--- rtl/sp_ram_wf.sv
////////////////////////////////////////////////////////////////////////////
// Single-port write-first block RAM. Read data is valid one cycle after
// the enable cycle, or two with OUT_REG set. During a write the read data
// follows the written word. Reset only clears the output register.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sp_ram_wf #(
   parameter int ADDR_W  = mem_pkg::ADDR_W,  // Word address width
   parameter int OUT_REG = 1                 // 1 adds an output register
) (
   input  logic                       i_clk,
   input  logic                       i_rst,    // Output register reset only
   input  logic                       i_en,     // Port enable
   input  logic                       i_we,     // Write enable, needs i_en
   input  logic [ADDR_W-1:0]          i_addr,
   input  logic [mem_pkg::DATA_W-1:0] i_wdata,
   output logic [mem_pkg::DATA_W-1:0] o_rdata
);
   import mem_pkg::*;

   logic [DATA_W-1:0] mem [0:(2**ADDR_W)-1];  // Storage array
   logic [DATA_W-1:0] ram_data;               // First stage read latch

   // Contents start at zero, as the block RAM does after configuration
   initial begin
      for (int i = 0; i < 2**ADDR_W; i++) begin
         mem[i] = '0;
      end
   end

   // Write-first port
   always @(posedge i_clk) begin
      if (i_en) begin
         if (i_we) begin
            mem[i_addr] <= i_wdata;
            ram_data    <= i_wdata;  // Read data shows the new word
         end else begin
            ram_data <= mem[i_addr];
         end
      end
   end

   generate
      if (OUT_REG != 0) begin : g_out_reg
         logic [DATA_W-1:0] rdata_q;  // Second stage, better clock-to-out

         always_ff @(posedge i_clk) begin
            if (i_rst) begin
               rdata_q <= '0;
            end else begin
               rdata_q <= ram_data;  // Advances every cycle
            end
         end

         assign o_rdata = rdata_q;
      end else begin : g_no_out_reg
         assign o_rdata = ram_data;  // Single cycle latency
      end
   endgenerate

endmodule

//--- rtl/block_sum_engine.sv
////////////////////////////////////////////////////////////////////////////
// Summing engine. On an accepted start it reads LEN words from BASE, one
// per cycle, and adds them modulo 2^32. Busy falls once the last word has
// been added, so the sum is final when busy reads low.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module block_sum_engine #(
   parameter int ADDR_W  = mem_pkg::ADDR_W,
   parameter int OUT_REG = 1
) (
   input  logic                       i_clk,
   input  logic                       i_rst,
   input  logic                       i_start,  // Ignored while busy
   input  logic [ADDR_W-1:0]          i_base,
   input  logic [ADDR_W:0]            i_len,
   input  logic [mem_pkg::DATA_W-1:0] i_rdata,  // RAM read data
   output logic                       o_req,    // RAM read request
   output logic [ADDR_W-1:0]          o_addr,
   output logic                       o_busy,
   output logic [mem_pkg::DATA_W-1:0] o_sum
);
   import mem_pkg::*;

   localparam int READ_LAT = read_lat(OUT_REG);

   sum_state_t          state;
   logic [ADDR_W-1:0]   addr_q;    // Next read address
   logic [ADDR_W:0]     remain;    // Reads still to issue
   logic [READ_LAT-1:0] vld_sr;    // One bit per read in flight
   logic [READ_LAT-1:0] vld_next;
   logic [DATA_W-1:0]   acc;

   assign o_req    = (state == SUM_RUN);
   assign vld_next = (vld_sr << 1) | READ_LAT'(o_req);

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state  <= SUM_IDLE;
         addr_q <= '0;
         remain <= '0;
         vld_sr <= '0;
         acc    <= '0;
      end else begin
         vld_sr <= vld_next;
         // Last stage lines up with the RAM data
         if (vld_sr[READ_LAT-1]) acc <= acc + i_rdata;

         case (state)
            SUM_IDLE: begin
               if (i_start) begin
                  acc    <= '0;
                  addr_q <= i_base;
                  remain <= i_len;
                  // Zero length still shows busy for one cycle
                  state  <= (i_len == '0) ? SUM_DRAIN : SUM_RUN;
               end
            end
            SUM_RUN: begin
               addr_q <= addr_q + 1'b1;
               remain <= remain - 1'b1;
               if (remain == (ADDR_W+1)'(1)) state <= SUM_DRAIN;
            end
            SUM_DRAIN: begin
               // Done once only the word added this cycle was left
               if (vld_next == '0) state <= SUM_IDLE;
            end
            default: state <= SUM_IDLE;
         endcase
      end
   end

   assign o_addr = addr_q;
   assign o_busy = (state != SUM_IDLE);
   assign o_sum  = acc;  // Partial while busy

endmodule

//--- rtl/apb_mem_slave.sv
////////////////////////////////////////////////////////////////////////////
// APB3 slave for the memory block. Bit 11 of the address picks registers
// or RAM words. Holds BASE and LEN, checks the range before it pulses the
// engine start, and hands the RAM port to the engine while it is busy.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module apb_mem_slave #(
   parameter int ADDR_W  = mem_pkg::ADDR_W,
   parameter int OUT_REG = 1
) (
   input  logic                        i_clk,
   input  logic                        i_rst,
   // APB side
   input  logic                        i_psel,
   input  logic                        i_penable,
   input  logic                        i_pwrite,
   input  logic [mem_pkg::PADDR_W-1:0] i_paddr,
   input  logic [mem_pkg::DATA_W-1:0]  i_pwdata,
   output logic                        o_pready,
   output logic [mem_pkg::DATA_W-1:0]  o_prdata,
   output logic                        o_pslverr,
   // RAM port
   output logic                        o_ram_en,
   output logic                        o_ram_we,
   output logic [ADDR_W-1:0]           o_ram_addr,
   output logic [mem_pkg::DATA_W-1:0]  o_ram_wdata,
   input  logic [mem_pkg::DATA_W-1:0]  i_ram_rdata,
   // Summing engine
   input  logic                        i_eng_req,
   input  logic [ADDR_W-1:0]           i_eng_addr,
   input  logic                        i_eng_busy,
   input  logic [mem_pkg::DATA_W-1:0]  i_eng_sum,
   output logic                        o_start,
   output logic [ADDR_W-1:0]           o_base,
   output logic [ADDR_W:0]             o_len
);
   import mem_pkg::*;

   localparam int READ_LAT = read_lat(OUT_REG);
   localparam logic [ADDR_W+1:0] DEPTH = (ADDR_W+2)'(2**ADDR_W);  // Words in RAM

   apb_state_t        state;
   logic              apb_setup;    // Setup phase of a new transfer
   logic              is_reg;       // Register half of the map
   logic              mem_q;        // Current transfer targets RAM
   logic              wr_q;         // Current transfer is a write
   logic [1:0]        lat_cnt;      // Cycles since the RAM read was issued
   logic [ADDR_W-1:0] addr_q;       // RAM word index
   logic [DATA_W-1:0] wdata_q;
   logic [DATA_W-1:0] reg_rdata_q;  // Register read value, taken at setup
   logic [ADDR_W-1:0] base_q;
   logic [ADDR_W:0]   len_q;
   logic [ADDR_W+1:0] range_end;    // BASE + LEN, one bit wider
   logic              range_bad;
   logic              start_req;    // CTRL write with bit 0 set
   logic [DATA_W-1:0] reg_val;
   logic              reg_err;
   logic              bus_en;
   logic              bus_we;

   assign apb_setup = i_psel && !i_penable;
   assign is_reg    = i_paddr[REG_SEL_BIT];
   assign range_end = {2'b00, base_q} + {1'b0, len_q};
   assign range_bad = range_end > DEPTH;
   assign start_req = i_pwrite && i_pwdata[0];

   // Register decode, read value and error for the address on the bus
   always_comb begin
      reg_val = '0;
      reg_err = 1'b0;
      case (i_paddr)
         REG_BASE: reg_val = DATA_W'(base_q);
         REG_LEN:  reg_val = DATA_W'(len_q);
         REG_CTRL: begin
            reg_val = DATA_W'(i_eng_busy);
            reg_err = start_req && range_bad;  // Refuse a start past the end
         end
         REG_SUM: begin
            reg_val = i_eng_sum;
            reg_err = i_pwrite;  // Read only
         end
         default: reg_err = 1'b1;  // Unmapped
      endcase
   end

   // Transfer FSM and control registers
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state   <= APB_IDLE;
         mem_q   <= 1'b0;
         wr_q    <= 1'b0;
         lat_cnt <= '0;
         base_q  <= '0;
         len_q   <= '0;
         o_start <= 1'b0;
      end else begin
         o_start <= 1'b0;  // Single cycle pulse
         case (state)
            APB_IDLE: begin
               if (apb_setup) begin
                  mem_q   <= !is_reg;
                  wr_q    <= i_pwrite;
                  lat_cnt <= '0;
                  if (is_reg) begin
                     if (reg_err) begin
                        state <= APB_ERR;
                     end else begin
                        state <= APB_MEM_DONE;  // Zero wait states
                        if (i_paddr == REG_BASE && i_pwrite) base_q <= i_pwdata[ADDR_W-1:0];
                        if (i_paddr == REG_LEN && i_pwrite) len_q <= i_pwdata[ADDR_W:0];
                        if (i_paddr == REG_CTRL) o_start <= start_req;
                     end
                  end else if (i_pwrite && !i_eng_busy) begin
                     state <= APB_MEM_DONE;  // Write lands in the access cycle
                  end else begin
                     state <= APB_MEM_WAIT;
                  end
               end
            end
            APB_MEM_WAIT: begin
               if (wr_q) begin
                  if (!i_eng_busy) state <= APB_MEM_DONE;
               end else if (lat_cnt != 2'd0 || !i_eng_busy) begin
                  // Read issued or in flight
                  lat_cnt <= lat_cnt + 2'd1;
                  if (lat_cnt + 2'd1 == 2'(READ_LAT)) state <= APB_MEM_DONE;
               end
            end
            APB_MEM_DONE: state <= APB_IDLE;
            APB_ERR:      state <= APB_IDLE;
            default:      state <= APB_IDLE;
         endcase
      end
   end

   // Transfer payload, captured at setup
   always_ff @(posedge i_clk) begin
      if (state == APB_IDLE && apb_setup) begin
         addr_q      <= i_paddr[ADDR_W+1:2];
         wdata_q     <= i_pwdata;
         reg_rdata_q <= reg_val;
      end
   end

   // Bus side RAM request
   assign bus_we = (state == APB_MEM_DONE) && mem_q && wr_q;
   assign bus_en = bus_we
                 || ((state == APB_MEM_WAIT) && !wr_q && (lat_cnt == 2'd0) && !i_eng_busy);

   // Engine owns the port while busy
   assign o_ram_en    = i_eng_busy ? i_eng_req : bus_en;
   assign o_ram_we    = i_eng_busy ? 1'b0 : bus_we;
   assign o_ram_addr  = i_eng_busy ? i_eng_addr : addr_q;
   assign o_ram_wdata = wdata_q;

   assign o_pready  = (state == APB_MEM_DONE) || (state == APB_ERR);
   assign o_pslverr = (state == APB_ERR);
   assign o_prdata  = mem_q ? i_ram_rdata : reg_rdata_q;  // RAM data valid with pready

   assign o_base = base_q;
   assign o_len  = len_q;

endmodule

//--- rtl/apb_sum_mem_top.sv
////////////////////////////////////////////////////////////////////////////
// Top of the APB memory block. Wires the APB slave, the write-first RAM
// and the summing engine together. ADDR_W sets the RAM depth, OUT_REG
// adds the RAM output register and one cycle of read latency.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module apb_sum_mem_top #(
   parameter int ADDR_W  = mem_pkg::ADDR_W,
   parameter int OUT_REG = 1
) (
   input  logic                        i_clk,
   input  logic                        i_rst,
   input  logic                        i_psel,
   input  logic                        i_penable,
   input  logic                        i_pwrite,
   input  logic [mem_pkg::PADDR_W-1:0] i_paddr,
   input  logic [mem_pkg::DATA_W-1:0]  i_pwdata,
   output logic                        o_pready,
   output logic [mem_pkg::DATA_W-1:0]  o_prdata,
   output logic                        o_pslverr
);
   import mem_pkg::*;

   // RAM port, muxed in the slave
   logic              ram_en;
   logic              ram_we;
   logic [ADDR_W-1:0] ram_addr;
   logic [DATA_W-1:0] ram_wdata;
   logic [DATA_W-1:0] ram_rdata;  // Shared by slave and engine

   // Engine handshake
   logic              eng_req;
   logic [ADDR_W-1:0] eng_addr;
   logic              eng_busy;
   logic [DATA_W-1:0] eng_sum;
   logic              start;
   logic [ADDR_W-1:0] base;
   logic [ADDR_W:0]   len;

   apb_mem_slave #(.ADDR_W(ADDR_W), .OUT_REG(OUT_REG)) u_slave (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_psel      (i_psel),
      .i_penable   (i_penable),
      .i_pwrite    (i_pwrite),
      .i_paddr     (i_paddr),
      .i_pwdata    (i_pwdata),
      .o_pready    (o_pready),
      .o_prdata    (o_prdata),
      .o_pslverr   (o_pslverr),
      .o_ram_en    (ram_en),
      .o_ram_we    (ram_we),
      .o_ram_addr  (ram_addr),
      .o_ram_wdata (ram_wdata),
      .i_ram_rdata (ram_rdata),
      .i_eng_req   (eng_req),
      .i_eng_addr  (eng_addr),
      .i_eng_busy  (eng_busy),
      .i_eng_sum   (eng_sum),
      .o_start     (start),
      .o_base      (base),
      .o_len       (len)
   );

   sp_ram_wf #(.ADDR_W(ADDR_W), .OUT_REG(OUT_REG)) u_ram (
      .i_clk   (i_clk),
      .i_rst   (i_rst),
      .i_en    (ram_en),
      .i_we    (ram_we),
      .i_addr  (ram_addr),
      .i_wdata (ram_wdata),
      .o_rdata (ram_rdata)
   );

   block_sum_engine #(.ADDR_W(ADDR_W), .OUT_REG(OUT_REG)) u_engine (
      .i_clk   (i_clk),
      .i_rst   (i_rst),
      .i_start (start),
      .i_base  (base),
      .i_len   (len),
      .i_rdata (ram_rdata),
      .o_req   (eng_req),
      .o_addr  (eng_addr),
      .o_busy  (eng_busy),
      .o_sum   (eng_sum)
   );

endmodule

//--- verif/tb_apb_sum_mem.sv
////////////////////////////////////////////////////////////////////////////
// Directed testbench for the APB memory block with its summing engine.
// Drives APB transfers on the falling edge, keeps a shadow copy of the RAM
// and checks reads and block sums against it. Runs with OUT_REG set to 1,
// and a run with OUT_REG at 0 is valid as well.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_apb_sum_mem;
   import mem_pkg::*;

   localparam int DEPTH          = 2**ADDR_W;
   localparam int XFER_LIMIT     = 400;    // Covers a stall behind a full run
   localparam int POLL_LIMIT     = 200;    // Busy polls before giving up
   localparam int TIMEOUT_CYCLES = 20000;  // About 4x the summed test length

   logic               i_clk;
   logic               i_rst;
   logic               i_psel;
   logic               i_penable;
   logic               i_pwrite;
   logic [PADDR_W-1:0] i_paddr;
   logic [DATA_W-1:0]  i_pwdata;
   logic               o_pready;
   logic [DATA_W-1:0]  o_prdata;
   logic               o_pslverr;

   logic [DATA_W-1:0] shadow [0:DEPTH-1];  // Reference copy of the RAM
   logic [31:0]       rng;                 // Xorshift state
   int                err_cnt;
   int                test_pass;
   int                test_fail;
   int                cycle_cnt;

   apb_sum_mem_top #(.ADDR_W(ADDR_W), .OUT_REG(1)) i_dut (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_psel    (i_psel),
      .i_penable (i_penable),
      .i_pwrite  (i_pwrite),
      .i_paddr   (i_paddr),
      .i_pwdata  (i_pwdata),
      .o_pready  (o_pready),
      .o_prdata  (o_prdata),
      .o_pslverr (o_pslverr)
   );

   initial begin
      i_clk = 1'b0;
      forever #20 i_clk = ~i_clk;  // 40 ns period
   end

   // Watchdog counting every rising edge
   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < TIMEOUT_CYCLES) begin
         @(posedge i_clk);
         cycle_cnt++;
      end
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Modulo 2^32 sum of a shadow range
   function automatic logic [31:0] model_sum(input int base, input int len);
      logic [31:0] s;
      s = '0;
      for (int k = 0; k < len; k++) begin
         s = s + shadow[base + k];
      end
      return s;
   endfunction

   task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) begin
         $display("[FAIL] t=%0t %s expected 0x%08h got 0x%08h", $time, name, exp, act);
         err_cnt++;
      end
   endtask

   // Setup and access phases sampled on the falling edge where outputs are settled
   task automatic apb_xfer(input logic wr, input logic [PADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] wdata,
                           output logic [DATA_W-1:0] rdata, output logic slverr);
      int waits;
      @(negedge i_clk);
      i_psel    = 1'b1;
      i_penable = 1'b0;
      i_pwrite  = wr;
      i_paddr   = addr;
      i_pwdata  = wdata;
      @(negedge i_clk);
      i_penable = 1'b1;
      waits     = 0;
      while (o_pready !== 1'b1 && waits < XFER_LIMIT) begin
         @(negedge i_clk);
         waits++;
      end
      if (o_pready !== 1'b1) begin
         $display("Transfer at 0x%03h got no pready within %0d cycles", addr, XFER_LIMIT);
         err_cnt++;
      end
      rdata  = o_prdata;
      slverr = o_pslverr;
      @(negedge i_clk);  // Transfer completed on the rising edge before
      i_psel    = 1'b0;
      i_penable = 1'b0;
   endtask

   task automatic apb_write(input logic [PADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                            output logic slverr);
      logic [DATA_W-1:0] unused;
      apb_xfer(1'b1, addr, data, unused, slverr);
   endtask

   task automatic apb_read(input logic [PADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                           output logic slverr);
      apb_xfer(1'b0, addr, '0, data, slverr);
   endtask

   // Poll CTRL until busy clears
   task automatic wait_idle();
      logic [DATA_W-1:0] ctrl;
      logic              err;
      int                polls;
      polls = 0;
      ctrl  = 32'h1;
      while (ctrl[0] && polls < POLL_LIMIT) begin
         apb_read(REG_CTRL, ctrl, err);
         polls++;
      end
      if (ctrl[0]) begin
         $display("Engine still busy after %0d status polls", POLL_LIMIT);
         err_cnt++;
      end
   endtask

   task automatic finish_test(input string name, input int errs_before);
      if (err_cnt == errs_before) begin
         $display("Test %s: passed", name);
         test_pass++;
      end else begin
         $display("Test %s: failed with %0d errors", name, err_cnt - errs_before);
         test_fail++;
      end
   endtask

   task automatic test_reset();
      logic [DATA_W-1:0] d;
      logic              err;
      int                e0;
      e0 = err_cnt;
      apb_read(REG_BASE, d, err);
      check_eq("BASE", 32'h0, d);
      apb_read(REG_LEN, d, err);
      check_eq("LEN", 32'h0, d);
      apb_read(REG_SUM, d, err);
      check_eq("SUM", 32'h0, d);
      apb_read(REG_CTRL, d, err);
      check_eq("CTRL busy", 32'h0, d);
      apb_read(12'h3FC, d, err);  // Last word
      check_eq("mem[255]", 32'h0, d);
      check_eq("pslverr", 32'h0, 32'(err));
      finish_test("reset", e0);
   endtask

   task automatic test_mem_rw();
      logic [DATA_W-1:0] d;
      logic              err;
      int                e0;
      e0 = err_cnt;
      for (int i = 0; i < DEPTH; i++) begin
         rng = xorshift32(rng);
         shadow[i] = rng;
         apb_write(PADDR_W'(i * 4), rng, err);
         check_eq("pslverr on write", 32'h0, 32'(err));
      end
      for (int i = 0; i < DEPTH; i++) begin
         apb_read(PADDR_W'(i * 4), d, err);
         check_eq($sformatf("mem[%0d]", i), shadow[i], d);
      end
      finish_test("memory write and read-back", e0);
   endtask

   task automatic test_regs();
      logic [DATA_W-1:0] d;
      logic              err;
      int                e0;
      e0 = err_cnt;
      apb_write(REG_BASE, 32'h5A, err);
      apb_read(REG_BASE, d, err);
      check_eq("BASE", 32'h5A, d);
      apb_write(REG_LEN, 32'h100, err);
      apb_read(REG_LEN, d, err);
      check_eq("LEN", 32'h100, d);
      apb_read(12'h810, d, err);  // Unmapped
      check_eq("pslverr at 0x810", 32'h1, 32'(err));
      apb_write(REG_SUM, 32'hDEADBEEF, err);  // Read only register
      check_eq("pslverr on SUM write", 32'h1, 32'(err));
      apb_read(REG_SUM, d, err);
      check_eq("SUM", 32'h0, d);  // No run yet so SUM keeps its reset value
      finish_test("register access", e0);
   endtask

   // Program a range, start, wait and compare with the model
   task automatic run_sum(input int base, input int len);
      logic [DATA_W-1:0] d;
      logic              err;
      apb_write(REG_BASE, 32'(base), err);
      apb_write(REG_LEN, 32'(len), err);
      apb_write(REG_CTRL, 32'h1, err);
      check_eq("pslverr on start", 32'h0, 32'(err));
      wait_idle();
      apb_read(REG_SUM, d, err);
      check_eq($sformatf("SUM base %0d len %0d", base, len), model_sum(base, len), d);
   endtask

   task automatic test_block_sum();
      int e0;
      int base;
      int len;
      e0 = err_cnt;
      run_sum(0, 1);
      run_sum(0, 256);  // Full RAM
      run_sum(255, 1);
      run_sum(200, 56);
      run_sum(17, 0);   // Empty range
      for (int n = 0; n < 4; n++) begin
         rng  = xorshift32(rng);
         base = int'(rng[7:0]);
         rng  = xorshift32(rng);
         len  = int'(rng % 32'(257 - base));
         run_sum(base, len);
      end
      finish_test("block sum", e0);
   endtask

   task automatic test_range_guard();
      logic [DATA_W-1:0] d;
      logic              err;
      int                e0;
      e0 = err_cnt;
      run_sum(10, 20);  // Known SUM before the refused starts
      apb_write(REG_BASE, 32'd250, err);
      apb_write(REG_LEN, 32'd10, err);
      apb_write(REG_CTRL, 32'h1, err);
      check_eq("pslverr on 250+10", 32'h1, 32'(err));
      apb_write(REG_BASE, 32'd0, err);
      apb_write(REG_LEN, 32'd257, err);
      apb_write(REG_CTRL, 32'h1, err);
      check_eq("pslverr on 0+257", 32'h1, 32'(err));
      apb_read(REG_CTRL, d, err);
      check_eq("CTRL busy", 32'h0, d);
      apb_read(REG_SUM, d, err);
      check_eq("SUM", model_sum(10, 20), d);
      finish_test("range guard", e0);
   endtask

   task automatic test_busy_access();
      logic [DATA_W-1:0] d;
      logic [DATA_W-1:0] exp_sum;
      logic [DATA_W-1:0] new_word;
      logic              err;
      int                e0;
      e0 = err_cnt;
      exp_sum  = model_sum(0, 256);  // Taken before the held write
      rng      = xorshift32(rng);
      new_word = rng;
      apb_write(REG_BASE, 32'd0, err);
      apb_write(REG_LEN, 32'd256, err);
      apb_write(REG_CTRL, 32'h1, err);
      apb_write(PADDR_W'(40 * 4), new_word, err);  // Stalls until busy falls
      check_eq("pslverr on held write", 32'h0, 32'(err));
      apb_read(PADDR_W'(100 * 4), d, err);
      check_eq("mem[100]", shadow[100], d);
      shadow[40] = new_word;
      apb_read(REG_CTRL, d, err);
      check_eq("CTRL busy", 32'h0, d);
      apb_read(REG_SUM, d, err);
      check_eq("SUM", exp_sum, d);
      apb_read(PADDR_W'(40 * 4), d, err);
      check_eq("mem[40]", shadow[40], d);
      finish_test("access during a run", e0);
   endtask

   initial begin
      i_rst     = 1'b1;
      i_psel    = 1'b0;
      i_penable = 1'b0;
      i_pwrite  = 1'b0;
      i_paddr   = '0;
      i_pwdata  = '0;
      rng       = 32'd35;  // Seed
      err_cnt   = 0;
      test_pass = 0;
      test_fail = 0;
      for (int i = 0; i < DEPTH; i++) begin
         shadow[i] = '0;
      end
      repeat (4) @(posedge i_clk);
      @(negedge i_clk);
      i_rst = 1'b0;

      test_reset();
      test_mem_rw();
      test_regs();
      test_block_sum();
      test_range_guard();
      test_busy_access();

      $display("Tests passed %0d, failed %0d, check errors %0d", test_pass, test_fail, err_cnt);
      if (err_cnt == 0 && test_fail == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

//--- sources.f
rtl/mem_pkg.sv
rtl/sp_ram_wf.sv
rtl/block_sum_engine.sv
rtl/apb_mem_slave.sv
rtl/apb_sum_mem_top.sv
verif/tb_apb_sum_mem.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the APB memory block testbench with Verilator, runs it and
# decides pass or fail from the simulation log.
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log
TOP=tb_apb_sum_mem

rm -rf "$BUILD_DIR" "$LOG_FILE"

verilator --binary --timing -Wno-fatal \
   -f sources.f \
   --top-module "$TOP" \
   -Mdir "$BUILD_DIR" \
   -o sim_tb

"./$BUILD_DIR/sim_tb" | tee "$LOG_FILE"

if grep -q "^Simulation finished: PASS$" "$LOG_FILE"; then
   echo "run_sim: pass message found in $LOG_FILE"
   exit 0
else
   echo "run_sim: pass message missing from $LOG_FILE"
   exit 1
fi
